//--- filelist.f
source/nvme_sq_pkg.sv
source/host_reg_decode.sv
source/sq_cmd_builder.sv
source/sq_queue.sv
source/host_readback.sv
source/nvme_sq_top.sv
tests/nvme_sq_chk.sv
tests/tb_nvme_sq.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_nvme_sq \
  -Mdir obj_dir -o sim_nvme_sq -f filelist.f || exit 1
out=$(./obj_dir/sim_nvme_sq)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED" && echo "run passed" || { echo "run failed"; exit 1; }

//--- tests/tb_nvme_sq.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nvme_sq import nvme_sq_pkg::*; ();

  localparam int DEPTH = 4;

  logic       clk;
  logic       rstn;
  logic       host_en;
  logic [3:0] host_we;
  host_addr_t host_addr;
  host_word_t host_din;
  host_word_t host_dout;

  logic [31:0] seed;
  int          checks;
  int          errors;

  // command fields as the host wrote them
  host_word_t  f_lba;
  host_word_t  f_dptr;
  logic [15:0] f_nlb;
  logic [7:0]  f_opc;
  cmd_id_t     exp_id;
  sq_ptr_t     exp_ptr;
  sq_entry_t   model_q[$];

  nvme_sq_top #(
    .SQ_DEPTH (DEPTH)
  ) i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic sq_entry_t model_entry(input cmd_id_t id);
    sq_entry_t e;
    e       = '0;
    e.cdw0  = {id, 8'h00, f_opc};
    e.cdw1  = 32'd1;              // default namespace
    e.cdw6  = f_dptr;
    e.cdw10 = f_lba;
    e.cdw12 = {16'h0000, f_nlb};
    return e;
  endfunction

  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic host_access(input logic [3:0] we, input host_addr_t addr,
                             input host_word_t din);
    host_en   = 1'b1;
    host_we   = we;
    host_addr = addr;
    host_din  = din;
    wait_clocks(1);  // sampled on this edge
    host_en = 1'b0;
    host_we = 4'h0;
  endtask

  task automatic write_reg(input host_addr_t addr, input host_word_t data);
    host_access(4'hF, addr, data);
    wait_clocks(1);
  endtask

  task automatic read_reg(input host_addr_t addr, output host_word_t data);
    host_access(4'h0, addr, 32'h0);
    data = host_dout;  // updated on the sampling edge
    wait_clocks(1);
  endtask

  task automatic expect_word(input string name, input host_word_t got,
                             input host_word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic load_fields();
    seed   = xorshift32(seed);
    f_lba  = seed;
    seed   = xorshift32(seed);
    f_dptr = seed;
    seed   = xorshift32(seed);
    f_nlb  = seed[31:16];
    f_opc  = seed[7:0];
    write_reg(ADDR_LBA, f_lba);
    write_reg(ADDR_DPTR, f_dptr);
    write_reg(ADDR_CNT_OPC, {f_nlb, 8'h00, f_opc});
  endtask

  task automatic push_cmd();
    write_reg(ADDR_PUSH, 32'h1);
    if (model_q.size() < DEPTH) begin  // dropped when full
      model_q.push_back(model_entry(exp_id));
      exp_id  = exp_id + 16'd1;
      exp_ptr = exp_ptr + 16'd1;
    end
  endtask

  task automatic clear_counters();
    write_reg(ADDR_CNT_RST, 32'h0);
    exp_id  = '0;
    exp_ptr = '0;
  endtask

  task automatic check_counters();
    host_word_t got;
    read_reg(ADDR_COUNTERS, got);
    expect_word("host_dout(counters)", got, {exp_id, exp_ptr});
  endtask

  // four lane reads per word, then a pop
  task automatic drain_entry();
    sq_entry_t  e;
    host_word_t got;
    host_addr_t lane_addr;
    if (model_q.size() == 0) begin
      errors++;
      $display("drain requested while no entry is expected");
    end else begin
      e = model_q.pop_front();
      for (int k = 0; k < 4; k++) begin
        for (int l = 0; l < 4; l++) begin
          lane_addr = ADDR_HEAD_W0 + host_addr_t'(4 * l);
          read_reg(lane_addr, got);
          expect_word($sformatf("host_dout(cdw%0d)", 4 * k + l), got,
                      e[32 * (4 * k + l) +: 32]);
        end
        read_reg(ADDR_POP, got);
      end
    end
  endtask

  initial begin
    host_word_t  got;
    int unsigned chk_fails;
    seed      = 32'h5bf3e602;
    checks    = 0;
    errors    = 0;
    exp_id    = '0;
    exp_ptr   = '0;
    rstn      = 1'b0;
    host_en   = 1'b0;
    host_we   = 4'h0;
    host_addr = '0;
    host_din  = '0;
    wait_clocks(5);
    rstn = 1'b1;
    wait_clocks(2);  // decoder arms one edge after release

    expect_word("host_dout", host_dout, 32'h0);
    check_counters();

    // single entry layout
    load_fields();
    push_cmd();
    drain_entry();
    check_counters();

    // push order and ids
    clear_counters();
    check_counters();
    for (int i = 0; i < 3; i++) begin
      load_fields();
      push_cmd();
    end
    check_counters();
    repeat (3) drain_entry();

    // one push more than the depth
    clear_counters();
    for (int i = 0; i < 5; i++) begin
      load_fields();
      push_cmd();
    end
    check_counters();
    repeat (4) drain_entry();

    // pops on an empty queue
    clear_counters();
    check_counters();
    repeat (3) read_reg(ADDR_POP, got);
    load_fields();
    push_cmd();
    drain_entry();
    check_counters();

    chk_fails = i_dut.i_queue.i_chk.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #100000;
    $display("simulation time limit reached before the test sequence ended");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/nvme_sq_chk.sv
`timescale 1ns/1ps
`default_nettype none

module nvme_sq_chk #(
  parameter int SQ_DEPTH = 4
) (
  input logic                           clk,
  input logic                           rstn,
  input logic                           push,
  input logic                           pop,
  input logic                           full,
  input logic                           empty,
  input logic [$clog2(SQ_DEPTH + 1)-1:0] count
);

  int unsigned fail_cnt = 0;  // summed by the testbench

  a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
    else begin
      fail_cnt++;
      $error("push strobe while the queue is full");
    end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty)
    else begin
      fail_cnt++;
      $error("pop strobe while the queue is empty");
    end

  // occupancy bound
  a_count_limit: assert property (@(posedge clk) disable iff (!rstn) count <= SQ_DEPTH)
    else begin
      fail_cnt++;
      $error("queue occupancy above depth");
    end

endmodule

bind sq_queue nvme_sq_chk #(
  .SQ_DEPTH (SQ_DEPTH)
) i_chk (
  .clk   (clk),
  .rstn  (rstn),
  .push  (push),
  .pop   (pop),
  .full  (full),
  .empty (empty),
  .count (count)
);

`default_nettype wire

//--- source/nvme_sq_top.sv
`timescale 1ns/1ps
`default_nettype none

module nvme_sq_top import nvme_sq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       host_en,
  input  logic [3:0] host_we,
  input  host_addr_t host_addr,
  input  host_word_t host_din,
  output host_word_t host_dout
);

  host_req_t req;
  host_op_t  op;
  sq_entry_t entry;
  sq_word_t  head_word;
  cmd_id_t   cmd_id;
  sq_ptr_t   head_ptr;
  logic      push;
  logic      pop;
  logic      full;
  logic      empty;

  assign req = '{en: host_en, we: host_we, addr: host_addr, din: host_din};

  host_reg_decode i_decode (
    .clk  (clk),
    .rstn (rstn),
    .req  (req),
    .op   (op)
  );

  sq_cmd_builder i_builder (
    .clk      (clk),
    .rstn     (rstn),
    .op       (op),
    .full     (full),
    .empty    (empty),
    .push     (push),
    .pop      (pop),
    .entry    (entry),
    .cmd_id   (cmd_id),
    .head_ptr (head_ptr)
  );

  sq_queue #(
    .SQ_DEPTH (SQ_DEPTH)
  ) i_queue (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .entry     (entry),
    .pop       (pop),
    .head_word (head_word),
    .full      (full),
    .empty     (empty)
  );

  host_readback i_readback (
    .clk       (clk),
    .rstn      (rstn),
    .op        (op),
    .head_word (head_word),
    .cmd_id    (cmd_id),
    .head_ptr  (head_ptr),
    .dout      (host_dout)
  );

endmodule

`default_nettype wire

//--- source/host_readback.sv
`timescale 1ns/1ps
`default_nettype none

module host_readback import nvme_sq_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  host_op_t   op,
  input  sq_word_t   head_word,
  input  cmd_id_t    cmd_id,
  input  sq_ptr_t    head_ptr,
  output host_word_t dout
);

  // dout holds until the next mapped read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dout <= '0;
    end else begin
      case (op.op)
        OP_HEAD_RD0: dout <= head_word[0 * 32 +: 32];
        OP_HEAD_RD1: dout <= head_word[1 * 32 +: 32];
        OP_HEAD_RD2: dout <= head_word[2 * 32 +: 32];
        OP_HEAD_RD3: dout <= head_word[3 * 32 +: 32];
        OP_CNT_RD:   dout <= {cmd_id, head_ptr};  // id high, ptr low
        default:     dout <= dout;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/sq_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sq_queue import nvme_sq_pkg::*; #(
  parameter int SQ_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      push,
  input  sq_entry_t entry,
  input  logic      pop,
  output sq_word_t  head_word,
  output logic      full,
  output logic      empty
);

  localparam int IDX_W  = $clog2(SQ_DEPTH);
  localparam int CNT_W  = $clog2(SQ_DEPTH + 1);
  localparam int WORD_W = $bits(sq_word_t);
  localparam int WORDS  = $bits(sq_entry_t) / WORD_W;

  sq_entry_t mem [SQ_DEPTH];

  logic [IDX_W-1:0]             wr_idx;
  logic [IDX_W-1:0]             rd_idx;
  logic [1:0]                   word_idx;  // quarter of head entry
  logic [CNT_W-1:0]             count;
  logic                         last_word;
  logic                         release_head;
  logic [$bits(sq_entry_t)-1:0] head_entry;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(SQ_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign last_word    = (word_idx == 2'(WORDS - 1));
  assign release_head = pop && last_word;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_idx] <= entry;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_idx   <= '0;
      rd_idx   <= '0;
      word_idx <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        wr_idx <= next_idx(wr_idx);
      end

      if (pop) begin
        word_idx <= last_word ? 2'd0 : word_idx + 2'd1;
      end
      if (release_head) begin
        rd_idx <= next_idx(rd_idx);  // entry freed after fourth word
      end

      case ({push, release_head})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_entry = mem[rd_idx];
  assign head_word  = head_entry[word_idx * WORD_W +: WORD_W];

  assign full  = (count == CNT_W'(SQ_DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

//--- source/sq_cmd_builder.sv
`timescale 1ns/1ps
`default_nettype none

module sq_cmd_builder import nvme_sq_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  host_op_t  op,
  input  logic      full,
  input  logic      empty,
  output logic      push,
  output logic      pop,
  output sq_entry_t entry,
  output cmd_id_t   cmd_id,
  output sq_ptr_t   head_ptr
);

  host_word_t  lba;
  host_word_t  dptr;
  logic [15:0] nlb;
  logic [7:0]  opcode;
  logic        push_ok;
  logic        pop_ok;

  // full push is dropped, counters untouched
  assign push_ok = (op.op == OP_PUSH) && !full;
  assign pop_ok  = (op.op == OP_POP) && !empty;

  // command fields and the entry snapshot
  always_ff @(posedge clk) begin
    case (op.op)
      OP_LBA_WR:  lba  <= op.data;
      OP_DPTR_WR: dptr <= op.data;
      OP_CNT_WR: begin
        nlb    <= op.data[31:16];
        opcode <= op.data[7:0];
      end
      default: ;
    endcase

    if (push_ok) begin
      entry       <= '0;
      entry.cdw0  <= {cmd_id, 8'h00, opcode};
      entry.cdw1  <= NSID_DEFAULT;
      entry.cdw6  <= dptr;
      entry.cdw10 <= lba;
      entry.cdw12 <= {16'h0000, nlb};  // nvme places nlb here
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      push     <= 1'b0;
      pop      <= 1'b0;
      cmd_id   <= '0;
      head_ptr <= '0;
    end else begin
      push <= push_ok;
      pop  <= pop_ok;

      if (op.op == OP_CNT_RST) begin
        cmd_id   <= '0;
        head_ptr <= '0;
      end else if (push_ok) begin
        cmd_id   <= cmd_id + cmd_id_t'(1);
        head_ptr <= head_ptr + sq_ptr_t'(1);  // doorbell value
      end
    end
  end

endmodule

`default_nettype wire

//--- source/host_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module host_reg_decode import nvme_sq_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  host_req_t req,
  output host_op_t  op
);

  logic armed;
  logic wr;
  logic rd;

  // bus is ignored until the first edge after reset release
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  assign wr = armed && req.en && (req.we != 4'h0);
  assign rd = armed && req.en && (req.we == 4'h0);

  always_comb begin
    op.op   = OP_NONE;
    op.data = req.din;
    if (wr) begin
      case (req.addr)
        ADDR_LBA:     op.op = OP_LBA_WR;
        ADDR_DPTR:    op.op = OP_DPTR_WR;
        ADDR_CNT_OPC: op.op = OP_CNT_WR;
        ADDR_PUSH:    op.op = OP_PUSH;
        ADDR_CNT_RST: op.op = OP_CNT_RST;
        default:      op.op = OP_NONE;  // unmapped write
      endcase
    end else if (rd) begin
      case (req.addr)
        ADDR_HEAD_W0:  op.op = OP_HEAD_RD0;
        ADDR_HEAD_W1:  op.op = OP_HEAD_RD1;
        ADDR_HEAD_W2:  op.op = OP_HEAD_RD2;
        ADDR_HEAD_W3:  op.op = OP_HEAD_RD3;
        ADDR_POP:      op.op = OP_POP;  // pop is a read access
        ADDR_COUNTERS: op.op = OP_CNT_RD;
        default:       op.op = OP_NONE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/nvme_sq_pkg.sv
`default_nettype none

package nvme_sq_pkg;

  typedef logic [14:0]  host_addr_t;
  typedef logic [31:0]  host_word_t;
  typedef logic [15:0]  cmd_id_t;
  typedef logic [15:0]  sq_ptr_t;
  typedef logic [127:0] sq_word_t;  // quarter of an entry

  // host register map
  localparam host_addr_t ADDR_LBA      = 15'h100;
  localparam host_addr_t ADDR_DPTR     = 15'h104;
  localparam host_addr_t ADDR_CNT_OPC  = 15'h108;
  localparam host_addr_t ADDR_PUSH     = 15'h110;
  localparam host_addr_t ADDR_HEAD_W0  = 15'h200;
  localparam host_addr_t ADDR_HEAD_W1  = 15'h204;
  localparam host_addr_t ADDR_HEAD_W2  = 15'h208;
  localparam host_addr_t ADDR_HEAD_W3  = 15'h20C;
  localparam host_addr_t ADDR_POP      = 15'h210;
  localparam host_addr_t ADDR_COUNTERS = 15'h214;
  localparam host_addr_t ADDR_CNT_RST  = 15'h300;

  localparam logic [31:0] NSID_DEFAULT = 32'd1;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_LBA_WR,
    OP_DPTR_WR,
    OP_CNT_WR,
    OP_PUSH,
    OP_CNT_RST,
    OP_HEAD_RD0,
    OP_HEAD_RD1,
    OP_HEAD_RD2,
    OP_HEAD_RD3,
    OP_POP,
    OP_CNT_RD
  } reg_op_e;

  // submission entry, dword 0 in the low bits
  typedef struct packed {
    logic [31:0] cdw15;
    logic [31:0] cdw14;
    logic [31:0] cdw13;
    logic [31:0] cdw12;  // block count in 15:0
    logic [31:0] cdw11;
    logic [31:0] cdw10;  // lba
    logic [31:0] cdw9;
    logic [31:0] cdw8;
    logic [31:0] cdw7;
    logic [31:0] cdw6;   // data pointer
    logic [31:0] cdw5;
    logic [31:0] cdw4;
    logic [31:0] cdw3;
    logic [31:0] cdw2;
    logic [31:0] cdw1;   // nsid
    logic [31:0] cdw0;   // cid 31:16, opcode 7:0
  } sq_entry_t;

  typedef struct packed {
    logic       en;
    logic [3:0] we;
    host_addr_t addr;
    host_word_t din;
  } host_req_t;

  typedef struct packed {
    reg_op_e    op;
    host_word_t data;
  } host_op_t;

endpackage

`default_nettype wire
